//--- Bender.yml
package:
  name: zports

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/zports_pkg.sv
      - hdl/port_decode.sv
      - hdl/xt_strobes.sv
      - hdl/config_regs.sv
      - hdl/port_read_mux.sv
      - hdl/zports.sv

  - target: test
    include_dirs:
      - hdl
      - verif
    files:
      - verif/zports_tb.sv

//--- hdl/config_regs.sv
// configuration register file
`timescale 1ns/1ps
`default_nettype none

`include "zports_settings.svh"

module config_regs
(
	input  wire logic                  clk,
	input  wire logic                  rst,
	input  wire logic [`ZP_DATA_W-1:0] din,
	input  wire logic [`ZP_ADDR_W-1:0] a,
	input  zports_pkg::port_sel_t      sel,
	input  wire logic                  iowr_s,
	input  wire logic                  iord_s,
	input  wire logic                  opfetch,
	output zports_pkg::cfg_t           cfg,
	output logic                       zvpage_wr,
	output logic [31:0]                xt_page
);

	localparam logic [7:0] RAMPAGE_BASE = `ZP_XT_RAMPAGE;

	zports_pkg::cfg_t cfg_q;
	logic             m1_lock128;
	logic [7:0]       a_hi;
	logic             xt_wr;
	logic             p7ffd_wr;
	logic             stat_rd;
	logic             lock128;

	assign a_hi = a[15:8];
	assign xt_wr = sel.xt & iowr_s;

	// 7FFD only with a15 low, ignored once 48K lock is set
	assign p7ffd_wr = sel.fd & ~a[15] & iowr_s & ~cfg_q.lck48;
	assign stat_rd  = sel.xt & iord_s & (a_hi == `ZP_XT_XSTAT);

	// memconf[7] picks the opcode-driven lock
	assign lock128 = cfg_q.memconf[7] ? m1_lock128 : cfg_q.memconf[6];

	// lock follows the opcode byte of each M1 cycle
	always_ff @(posedge clk)
	begin
		if (rst)
			m1_lock128 <= 1'b0;
		else if (opfetch)
			m1_lock128 <= ~(din[7] ^ din[6]);
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			cfg_q.rampage[0] <= `ZP_RST_PAGE0;
			cfg_q.rampage[1] <= `ZP_RST_PAGE1;
			cfg_q.rampage[2] <= `ZP_RST_PAGE2;
			cfg_q.rampage[3] <= `ZP_RST_PAGE3;
			cfg_q.sysconf    <= `ZP_RST_SYSCONF;
			cfg_q.memconf    <= `ZP_RST_MEMCONF;
			cfg_q.im2vect    <= `ZP_RST_IM2VECT;
			cfg_q.fmaddr[4]  <= 1'b0;   // fm window off, address kept
			cfg_q.fddvirt    <= '0;
			cfg_q.lck48      <= 1'b0;
			cfg_q.pwr_up     <= 1'b1;
		end
		else
		begin
			if (p7ffd_wr)
			begin
				cfg_q.memconf[0] <= din[4];   // rom select
				cfg_q.rampage[3] <= {3'b000, lock128 ? 2'b00 : din[7:6], din[2:0]};
				cfg_q.lck48      <= din[5];
			end
			else if (xt_wr)
			begin
				if (a_hi[7:2] == RAMPAGE_BASE[7:2])
					cfg_q.rampage[a_hi[1:0]] <= din;
				if (a_hi == `ZP_XT_FMADDR)
					cfg_q.fmaddr <= din[`ZP_FMADDR_W-1:0];
				if (a_hi == `ZP_XT_SYSCONF)
					cfg_q.sysconf <= din;
				if (a_hi == `ZP_XT_MEMCONF)
					cfg_q.memconf <= din;
				if (a_hi == `ZP_XT_IM2VECT)
					cfg_q.im2vect <= din;
				if (a_hi == `ZP_XT_FDDVIRT)
					cfg_q.fddvirt <= din[`ZP_FDDVIRT_W-1:0];
			end

			// power-up flag is read once, then gone
			if (stat_rd)
				cfg_q.pwr_up <= 1'b0;
		end
	end

	assign cfg       = cfg_q;
	assign zvpage_wr = p7ffd_wr;
	assign xt_page   = cfg_q.rampage;   // page 3 in the top byte

endmodule

`default_nettype wire

//--- hdl/port_decode.sv
// port address decoder
`timescale 1ns/1ps
`default_nettype none

`include "zports_settings.svh"

module port_decode
(
	input  wire logic [`ZP_ADDR_W-1:0] a,
	output zports_pkg::port_sel_t      sel,
	output logic                       porthit
);

	logic [7:0] loa;

	assign loa = a[7:0];

	// only the low byte selects the port
	always_comb
	begin
		sel        = '0;
		sel.fe     = (loa == `ZP_PORT_FE);
		sel.xt     = (loa == `ZP_PORT_XT);
		sel.fd     = (loa == `ZP_PORT_FD);    // a[15] is checked by the paging logic
		sel.covox  = (loa == `ZP_PORT_COVOX);
		sel.kjoy   = (loa == `ZP_PORT_KJOY);
		sel.kmouse = (loa == `ZP_PORT_KMOUSE);
	end

	// any internal port
	assign porthit = |sel;

endmodule

`default_nettype wire

//--- hdl/port_read_mux.sv
// port read data select
`timescale 1ns/1ps
`default_nettype none

`include "zports_settings.svh"

module port_read_mux
(
	input  wire logic [7:0]            a_hi,
	input  zports_pkg::port_sel_t      sel,
	input  zports_pkg::cfg_t           cfg,
	input  wire logic [`ZP_KEYS_W-1:0] keys_in,
	input  wire logic                  tape_read,
	input  wire logic [`ZP_KJOY_W-1:0] kj_in,
	input  wire logic [`ZP_DATA_W-1:0] mus_in,
	input  wire logic                  dma_act,
	output logic [`ZP_DATA_W-1:0]      dout
);

	always_comb
	begin
		dout = `ZP_UNMAPPED;
		if (sel.fe)
			dout = {1'b1, tape_read, 1'b0, keys_in};
		else if (sel.kjoy)
			dout = {{(`ZP_DATA_W - `ZP_KJOY_W){1'b0}}, kj_in};
		else if (sel.kmouse)
			dout = mus_in;
		else if (sel.xt)
		begin
			case (a_hi)
			`ZP_XT_XSTAT:
				dout = {1'b0, cfg.pwr_up, 6'b000000};
			`ZP_XT_DMASTAT:
				dout = {dma_act, 7'b0000000};
			`ZP_XT_RAMPAGE + 8'd2, `ZP_XT_RAMPAGE + 8'd3:
				dout = cfg.rampage[a_hi[1:0]];   // only upper pages read back
			default:
				dout = `ZP_UNMAPPED;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- hdl/xt_strobes.sv
// extended port write strobes
`timescale 1ns/1ps
`default_nettype none

`include "zports_settings.svh"

module xt_strobes
(
	input  wire logic [7:0]         a_hi,
	input  zports_pkg::port_sel_t   sel,
	input  wire logic               iowr_s,
	output zports_pkg::vid_wr_t     vid_wr,
	output zports_pkg::dma_wr_t     dma_wr,
	output logic                    beeper_wr,
	output logic                    covox_wr
);

	logic xt_wr;
	logic fe_wr;

	assign xt_wr = sel.xt & iowr_s;
	assign fe_wr = sel.fe & iowr_s;

	always_comb
	begin
		vid_wr = '0;
		dma_wr = '0;
		vid_wr.zborder_wr = fe_wr;   // FE writes the border too
		if (xt_wr)
		begin
			case (a_hi)
			`ZP_XT_VCONF:     vid_wr.vconf_wr     = 1'b1;
			`ZP_XT_VPAGE:     vid_wr.vpage_wr     = 1'b1;
			`ZP_XT_GXOFFSL:   vid_wr.gx_offsl_wr  = 1'b1;
			`ZP_XT_GXOFFSH:   vid_wr.gx_offsh_wr  = 1'b1;
			`ZP_XT_GYOFFSL:   vid_wr.gy_offsl_wr  = 1'b1;
			`ZP_XT_GYOFFSH:   vid_wr.gy_offsh_wr  = 1'b1;
			`ZP_XT_TSCONF:    vid_wr.tsconf_wr    = 1'b1;
			`ZP_XT_PALSEL:    vid_wr.palsel_wr    = 1'b1;
			`ZP_XT_XBORDER:   vid_wr.border_wr    = 1'b1;
			`ZP_XT_TMPAGE:    vid_wr.tmpage_wr    = 1'b1;
			`ZP_XT_T0GPAGE:   vid_wr.t0gpage_wr   = 1'b1;
			`ZP_XT_T1GPAGE:   vid_wr.t1gpage_wr   = 1'b1;
			`ZP_XT_SGPAGE:    vid_wr.sgpage_wr    = 1'b1;
			`ZP_XT_HSINT:     vid_wr.hint_beg_wr  = 1'b1;
			`ZP_XT_VSINTL:    vid_wr.vint_begl_wr = 1'b1;
			`ZP_XT_VSINTH:    vid_wr.vint_begh_wr = 1'b1;
			`ZP_XT_T0XOFFSL:  vid_wr.t0x_offsl_wr = 1'b1;
			`ZP_XT_T0XOFFSH:  vid_wr.t0x_offsh_wr = 1'b1;
			`ZP_XT_T0YOFFSL:  vid_wr.t0y_offsl_wr = 1'b1;
			`ZP_XT_T0YOFFSH:  vid_wr.t0y_offsh_wr = 1'b1;
			`ZP_XT_T1XOFFSL:  vid_wr.t1x_offsl_wr = 1'b1;
			`ZP_XT_T1XOFFSH:  vid_wr.t1x_offsh_wr = 1'b1;
			`ZP_XT_T1YOFFSL:  vid_wr.t1y_offsl_wr = 1'b1;
			`ZP_XT_T1YOFFSH:  vid_wr.t1y_offsh_wr = 1'b1;
			`ZP_XT_DMASADDRL: dma_wr.saddrl       = 1'b1;
			`ZP_XT_DMASADDRH: dma_wr.saddrh       = 1'b1;
			`ZP_XT_DMASADDRX: dma_wr.saddrx       = 1'b1;
			`ZP_XT_DMADADDRL: dma_wr.daddrl       = 1'b1;
			`ZP_XT_DMADADDRH: dma_wr.daddrh       = 1'b1;
			`ZP_XT_DMADADDRX: dma_wr.daddrx       = 1'b1;
			`ZP_XT_DMALEN:    dma_wr.len          = 1'b1;
			`ZP_XT_DMACTRL:   dma_wr.ctrl         = 1'b1;
			`ZP_XT_DMANUM:    dma_wr.num          = 1'b1;
			default:          ;   // handled in config_regs or unused
			endcase
		end
	end

	assign beeper_wr = fe_wr;
	assign covox_wr  = sel.covox & iowr_s;

endmodule

`default_nettype wire

//--- hdl/zports.sv
// system port block
`timescale 1ns/1ps
`default_nettype none

`include "zports_settings.svh"

module zports
(
	input  wire logic                  clk,
	input  wire logic                  rst,

	// cpu side
	input  wire logic [`ZP_ADDR_W-1:0] a,
	input  wire logic [`ZP_DATA_W-1:0] din,
	output logic [`ZP_DATA_W-1:0]      dout,
	input  wire logic                  iowr_s,
	input  wire logic                  iord_s,
	input  wire logic                  opfetch,   // din holds the opcode
	output logic                       porthit,

	// read sources
	input  wire logic [`ZP_KEYS_W-1:0] keys_in,
	input  wire logic                  tape_read,
	input  wire logic [`ZP_KJOY_W-1:0] kj_in,
	input  wire logic [`ZP_DATA_W-1:0] mus_in,
	input  wire logic                  dma_act,

	// write strobes
	output zports_pkg::vid_wr_t        vid_wr,
	output zports_pkg::dma_wr_t        dma_wr,
	output logic                       beeper_wr,
	output logic                       covox_wr,
	output logic                       zvpage_wr,

	// register state
	output logic [31:0]                xt_page,
	output zports_pkg::cfg_t           cfg
);

	zports_pkg::port_sel_t sel;

	port_decode port_decode_inst
	(
		.a       (a),
		.sel     (sel),
		.porthit (porthit)
	);

	xt_strobes xt_strobes_inst
	(
		.a_hi      (a[15:8]),
		.sel       (sel),
		.iowr_s    (iowr_s),
		.vid_wr    (vid_wr),
		.dma_wr    (dma_wr),
		.beeper_wr (beeper_wr),
		.covox_wr  (covox_wr)
	);

	config_regs config_regs_inst
	(
		.clk       (clk),
		.rst       (rst),
		.din       (din),
		.a         (a),
		.sel       (sel),
		.iowr_s    (iowr_s),
		.iord_s    (iord_s),
		.opfetch   (opfetch),
		.cfg       (cfg),
		.zvpage_wr (zvpage_wr),
		.xt_page   (xt_page)
	);

	port_read_mux port_read_mux_inst
	(
		.a_hi      (a[15:8]),
		.sel       (sel),
		.cfg       (cfg),
		.keys_in   (keys_in),
		.tape_read (tape_read),
		.kj_in     (kj_in),
		.mus_in    (mus_in),
		.dma_act   (dma_act),
		.dout      (dout)
	);

endmodule

`default_nettype wire

//--- hdl/zports_pkg.sv
// system port types
`default_nettype none

`include "zports_settings.svh"

package zports_pkg;

	// one flag per internal port, set on low byte match
	typedef struct packed {
		logic fe;
		logic xt;
		logic fd;
		logic covox;
		logic kjoy;
		logic kmouse;
	} port_sel_t;

	// video, tile and interrupt register strobes
	typedef struct packed {
		logic zborder_wr;   // port FE border
		logic border_wr;
		logic vpage_wr;
		logic vconf_wr;
		logic gx_offsl_wr;
		logic gx_offsh_wr;
		logic gy_offsl_wr;
		logic gy_offsh_wr;
		logic t0x_offsl_wr;
		logic t0x_offsh_wr;
		logic t0y_offsl_wr;
		logic t0y_offsh_wr;
		logic t1x_offsl_wr;
		logic t1x_offsh_wr;
		logic t1y_offsl_wr;
		logic t1y_offsh_wr;
		logic tsconf_wr;
		logic palsel_wr;
		logic tmpage_wr;
		logic t0gpage_wr;
		logic t1gpage_wr;
		logic sgpage_wr;
		logic hint_beg_wr;
		logic vint_begl_wr;
		logic vint_begh_wr;
	} vid_wr_t;

	// dma register strobes
	typedef struct packed {
		logic saddrl;
		logic saddrh;
		logic saddrx;
		logic daddrl;
		logic daddrh;
		logic daddrx;
		logic len;
		logic ctrl;
		logic num;
	} dma_wr_t;

	// register file state
	typedef struct packed {
		logic [`ZP_PAGES-1:0][`ZP_DATA_W-1:0] rampage;  // [0] in the low byte
		logic [`ZP_DATA_W-1:0]    sysconf;
		logic [`ZP_DATA_W-1:0]    memconf;
		logic [`ZP_DATA_W-1:0]    im2vect;
		logic [`ZP_FMADDR_W-1:0]  fmaddr;
		logic [`ZP_FDDVIRT_W-1:0] fddvirt;
		logic                     lck48;    // 7FFD locked until reset
		logic                     pwr_up;
	} cfg_t;

endpackage

`default_nettype wire

//--- hdl/zports_settings.svh
// system port settings
`ifndef ZPORTS_SETTINGS_SVH
`define ZPORTS_SETTINGS_SVH

// bus and field widths
`define ZP_DATA_W       8
`define ZP_ADDR_W       16
`define ZP_KEYS_W       5
`define ZP_KJOY_W       5
`define ZP_FMADDR_W     5
`define ZP_FDDVIRT_W    4
`define ZP_PAGES        4

// low address byte of each internal port
`define ZP_PORT_FE      8'hFE   // keyboard, tape, border, beeper
`define ZP_PORT_FD      8'hFD   // 7FFD paging
`define ZP_PORT_XT      8'hAF   // extended registers, index in a[15:8]
`define ZP_PORT_COVOX   8'hFB
`define ZP_PORT_KJOY    8'h1F   // kempston joystick
`define ZP_PORT_KMOUSE  8'hDF   // kempston mouse

// extended register indexes
`define ZP_XT_VCONF     8'h00
`define ZP_XT_VPAGE     8'h01
`define ZP_XT_GXOFFSL   8'h02
`define ZP_XT_GXOFFSH   8'h03
`define ZP_XT_GYOFFSL   8'h04
`define ZP_XT_GYOFFSH   8'h05
`define ZP_XT_TSCONF    8'h06
`define ZP_XT_PALSEL    8'h07
`define ZP_XT_XBORDER   8'h0F
`define ZP_XT_RAMPAGE   8'h10   // four pages, 10..13
`define ZP_XT_FMADDR    8'h15
`define ZP_XT_TMPAGE    8'h16
`define ZP_XT_T0GPAGE   8'h17
`define ZP_XT_T1GPAGE   8'h18
`define ZP_XT_SGPAGE    8'h19
`define ZP_XT_DMASADDRL 8'h1A
`define ZP_XT_DMASADDRH 8'h1B
`define ZP_XT_DMASADDRX 8'h1C
`define ZP_XT_DMADADDRL 8'h1D
`define ZP_XT_DMADADDRH 8'h1E
`define ZP_XT_DMADADDRX 8'h1F
`define ZP_XT_SYSCONF   8'h20
`define ZP_XT_MEMCONF   8'h21
`define ZP_XT_HSINT     8'h22
`define ZP_XT_VSINTL    8'h23
`define ZP_XT_VSINTH    8'h24
`define ZP_XT_IM2VECT   8'h25
`define ZP_XT_DMALEN    8'h26
`define ZP_XT_DMACTRL   8'h27
`define ZP_XT_DMANUM    8'h28
`define ZP_XT_FDDVIRT   8'h29
`define ZP_XT_T0XOFFSL  8'h40
`define ZP_XT_T0XOFFSH  8'h41
`define ZP_XT_T0YOFFSL  8'h42
`define ZP_XT_T0YOFFSH  8'h43
`define ZP_XT_T1XOFFSL  8'h44
`define ZP_XT_T1XOFFSH  8'h45
`define ZP_XT_T1YOFFSL  8'h46
`define ZP_XT_T1YOFFSH  8'h47

// read-only indexes, shared with write indexes above
`define ZP_XT_XSTAT     8'h00
`define ZP_XT_DMASTAT   8'h27

// reset values
`define ZP_RST_SYSCONF  8'h01   // turbo 7 MHz
`define ZP_RST_MEMCONF  8'h04   // no map
`define ZP_RST_IM2VECT  8'hFF
`define ZP_RST_PAGE0    8'h00
`define ZP_RST_PAGE1    8'h05
`define ZP_RST_PAGE2    8'h02
`define ZP_RST_PAGE3    8'h00

`define ZP_UNMAPPED     8'hFF

`endif

//--- verif/zports_ref.svh
// port reference functions
`ifndef ZPORTS_REF_SVH
`define ZPORTS_REF_SVH

// extended index of each vid_wr bit from border_wr down to vint_begh_wr
localparam logic [23:0][7:0] VID_IDX = {
	`ZP_XT_XBORDER, `ZP_XT_VPAGE, `ZP_XT_VCONF,
	`ZP_XT_GXOFFSL, `ZP_XT_GXOFFSH, `ZP_XT_GYOFFSL, `ZP_XT_GYOFFSH,
	`ZP_XT_T0XOFFSL, `ZP_XT_T0XOFFSH, `ZP_XT_T0YOFFSL, `ZP_XT_T0YOFFSH,
	`ZP_XT_T1XOFFSL, `ZP_XT_T1XOFFSH, `ZP_XT_T1YOFFSL, `ZP_XT_T1YOFFSH,
	`ZP_XT_TSCONF, `ZP_XT_PALSEL, `ZP_XT_TMPAGE, `ZP_XT_T0GPAGE,
	`ZP_XT_T1GPAGE, `ZP_XT_SGPAGE, `ZP_XT_HSINT, `ZP_XT_VSINTL, `ZP_XT_VSINTH
};

// dma strobe order, saddrl in the top bit
localparam logic [8:0][7:0] DMA_IDX = {
	`ZP_XT_DMASADDRL, `ZP_XT_DMASADDRH, `ZP_XT_DMASADDRX,
	`ZP_XT_DMADADDRL, `ZP_XT_DMADADDRH, `ZP_XT_DMADADDRX,
	`ZP_XT_DMALEN, `ZP_XT_DMACTRL, `ZP_XT_DMANUM
};

function automatic logic exp_porthit(input logic [15:0] addr);
	logic [7:0] lo;
	lo = addr[7:0];
	return lo == `ZP_PORT_FE || lo == `ZP_PORT_XT || lo == `ZP_PORT_FD ||
		lo == `ZP_PORT_COVOX || lo == `ZP_PORT_KJOY || lo == `ZP_PORT_KMOUSE;
endfunction

function automatic logic [7:0] exp_dout(input logic [15:0] addr, input zports_pkg::cfg_t c,
	input logic [4:0] keys, input logic tape, input logic [4:0] kj, input logic [7:0] mus,
	input logic dma);
	logic [7:0] r;
	r = `ZP_UNMAPPED;
	if (addr[7:0] == `ZP_PORT_FE)
		r = {1'b1, tape, 1'b0, keys};
	else if (addr[7:0] == `ZP_PORT_KJOY)
		r = {3'b000, kj};
	else if (addr[7:0] == `ZP_PORT_KMOUSE)
		r = mus;
	else if (addr[7:0] == `ZP_PORT_XT)
	begin
		if (addr[15:8] == `ZP_XT_XSTAT)
			r = {1'b0, c.pwr_up, 6'b000000};
		else if (addr[15:8] == `ZP_XT_DMASTAT)
			r = {dma, 7'b0000000};
		else if (addr[15:8] == `ZP_XT_RAMPAGE + 8'd2)
			r = c.rampage[2];
		else if (addr[15:8] == `ZP_XT_RAMPAGE + 8'd3)
			r = c.rampage[3];
	end
	return r;
endfunction

function automatic zports_pkg::vid_wr_t exp_vid(input logic [15:0] addr, input logic wr);
	zports_pkg::vid_wr_t v;
	v = '0;
	v.zborder_wr = wr && addr[7:0] == `ZP_PORT_FE;
	for (int i = 0; i < 24; i++)
		v[i] = wr && addr[7:0] == `ZP_PORT_XT && addr[15:8] == VID_IDX[i];
	return v;
endfunction

function automatic zports_pkg::dma_wr_t exp_dma(input logic [15:0] addr, input logic wr);
	zports_pkg::dma_wr_t d;
	for (int i = 0; i < 9; i++)
		d[i] = wr && addr[7:0] == `ZP_PORT_XT && addr[15:8] == DMA_IDX[i];
	return d;
endfunction

// 128K lock clears the two upper page bits
function automatic logic [7:0] exp_page3(input logic [7:0] data, input logic lock);
	return {3'b000, lock ? 2'b00 : data[7:6], data[2:0]};
endfunction

`endif

//--- verif/zports_tb.sv
// system port testbench
`timescale 1ns/1ps
`default_nettype none

`include "zports_settings.svh"

module zports_tb;

	logic                  clk;
	logic                  rst;
	logic [`ZP_ADDR_W-1:0] a;
	logic [`ZP_DATA_W-1:0] din;
	logic                  iowr_s;
	logic                  iord_s;
	logic                  opfetch;
	logic [`ZP_KEYS_W-1:0] keys_in;
	logic                  tape_read;
	logic [`ZP_KJOY_W-1:0] kj_in;
	logic [`ZP_DATA_W-1:0] mus_in;
	logic                  dma_act;
	logic [`ZP_DATA_W-1:0] dout;
	logic                  porthit;
	zports_pkg::vid_wr_t   vid_wr;
	zports_pkg::dma_wr_t   dma_wr;
	logic                  beeper_wr;
	logic                  covox_wr;
	logic                  zvpage_wr;
	logic [31:0]           xt_page;
	zports_pkg::cfg_t      cfg;

	zports_pkg::cfg_t m;   // shadow of cfg
	logic             m1_lock;
	logic             fd_wr_exp;
	int               errors;
	int               timeouts;

	`include "zports_ref.svh"

	localparam logic [8:0][7:0] CFG_IDX = {
		`ZP_XT_RAMPAGE, `ZP_XT_RAMPAGE + 8'd1, `ZP_XT_RAMPAGE + 8'd2, `ZP_XT_RAMPAGE + 8'd3,
		`ZP_XT_SYSCONF, `ZP_XT_MEMCONF, `ZP_XT_IM2VECT, `ZP_XT_FMADDR, `ZP_XT_FDDVIRT
	};
	localparam logic [3:0][7:0] RD_IDX = {
		`ZP_XT_XSTAT, `ZP_XT_DMASTAT, `ZP_XT_RAMPAGE + 8'd2, `ZP_XT_RAMPAGE + 8'd3
	};

	zports zports_inst (.*);

	initial
	begin
		clk = 1'b0;
		forever
			#20 clk = ~clk;
	end

	// read sources change every cycle
	always @(posedge clk)
	begin
		keys_in   <= $urandom;
		tape_read <= $urandom;
		kj_in     <= $urandom;
		mus_in    <= $urandom;
		dma_act   <= $urandom;
	end

	assign fd_wr_exp = iowr_s && a[7:0] == `ZP_PORT_FD && !a[15] && !m.lck48;

	always @(posedge clk)
	begin : model_update
		logic       lock;
		logic [7:0] off;
		lock = m.memconf[7] ? m1_lock : m.memconf[6];   // state before this edge
		off  = a[15:8] - `ZP_XT_RAMPAGE;
		if (rst)
		begin
			m.rampage   = {`ZP_RST_PAGE3, `ZP_RST_PAGE2, `ZP_RST_PAGE1, `ZP_RST_PAGE0};
			m.sysconf   = `ZP_RST_SYSCONF;
			m.memconf   = `ZP_RST_MEMCONF;
			m.im2vect   = `ZP_RST_IM2VECT;
			m.fmaddr[4] = 1'b0;
			m.fddvirt   = '0;
			m.lck48     = 1'b0;
			m.pwr_up    = 1'b1;
			m1_lock     = 1'b0;
		end
		else
		begin
			if (opfetch)
				m1_lock = ~(din[7] ^ din[6]);
			if (fd_wr_exp)
			begin
				m.memconf[0] = din[4];
				m.rampage[3] = exp_page3(din, lock);
				m.lck48      = din[5];
			end
			else if (iowr_s && a[7:0] == `ZP_PORT_XT)
			begin
				if (off < 8'd4)
					m.rampage[off[1:0]] = din;
				case (a[15:8])
				`ZP_XT_SYSCONF: m.sysconf = din;
				`ZP_XT_MEMCONF: m.memconf = din;
				`ZP_XT_IM2VECT: m.im2vect = din;
				`ZP_XT_FMADDR:  m.fmaddr  = din[4:0];
				`ZP_XT_FDDVIRT: m.fddvirt = din[3:0];
				default:        ;
				endcase
			end
			if (iord_s && a[7:0] == `ZP_PORT_XT && a[15:8] == `ZP_XT_XSTAT)
				m.pwr_up = 1'b0;
		end
	end

	task automatic report_mismatch(input string msg);
		$display("MISMATCH at %0t: %s", $time, msg);
		errors++;
	endtask

	// outputs are settled halfway through the cycle
	always @(negedge clk)
	begin
		if (!rst)
		begin
			assert (cfg === m)
			else report_mismatch($sformatf("cfg %h, expected %h", cfg, m));
			assert (xt_page === m.rampage)
			else report_mismatch($sformatf("xt_page %h, expected %h", xt_page, m.rampage));
			assert (porthit === exp_porthit(a))
			else report_mismatch($sformatf("porthit %b at a=%h", porthit, a));
			assert (dout === exp_dout(a, m, keys_in, tape_read, kj_in, mus_in, dma_act))
			else report_mismatch($sformatf("dout %h at a=%h", dout, a));
			assert (vid_wr === exp_vid(a, iowr_s))
			else report_mismatch($sformatf("vid_wr %h at a=%h wr=%b", vid_wr, a, iowr_s));
			assert (dma_wr === exp_dma(a, iowr_s))
			else report_mismatch($sformatf("dma_wr %h at a=%h wr=%b", dma_wr, a, iowr_s));
			assert (beeper_wr === (iowr_s && a[7:0] == `ZP_PORT_FE))
			else report_mismatch($sformatf("beeper_wr %b at a=%h", beeper_wr, a));
			assert (covox_wr === (iowr_s && a[7:0] == `ZP_PORT_COVOX))
			else report_mismatch($sformatf("covox_wr %b at a=%h", covox_wr, a));
			assert (zvpage_wr === fd_wr_exp)
			else report_mismatch($sformatf("zvpage_wr %b at a=%h", zvpage_wr, a));
		end
	end

	task automatic drive(input logic [15:0] addr, input logic [7:0] data,
		input logic wr, input logic rd, input logic op);
		@(posedge clk);
		a       <= addr;
		din     <= data;
		iowr_s  <= wr;
		iord_s  <= rd;
		opfetch <= op;
	endtask

	task automatic wait_pwr_up(input logic val, input string what);
		int n;
		n = 0;
		@(negedge clk);
		while (cfg.pwr_up !== val && n < 10)
		begin
			@(negedge clk);
			n++;
		end
		if (cfg.pwr_up !== val)
		begin
			$display("timeout after %0d cycles waiting for %s", n, what);
			timeouts++;
		end
	endtask

	// random 7FFD writes with a15 low and bit 5 clear
	task automatic write_7ffd(input int n);
		logic [7:0] hi;
		logic [7:0] d;
		repeat (n)
		begin
			hi = $urandom;
			d  = $urandom;
			drive({1'b0, hi[6:0], `ZP_PORT_FD}, d & 8'hDF, 1'b1, 1'b0, 1'b0);
		end
	endtask

	initial
	begin
		logic [7:0] idx;
		logic [7:0] lo;
		errors   = 0;
		timeouts = 0;
		void'($urandom(32'hb0bf));
		rst       = 1'b1;
		a         = '0;
		din       = '0;
		iowr_s    = 1'b0;
		iord_s    = 1'b0;
		opfetch   = 1'b0;
		keys_in   = '0;
		tape_read = 1'b0;
		kj_in     = '0;
		mus_in    = '0;
		dma_act   = 1'b0;
		repeat (5) @(posedge clk);
		rst <= 1'b0;
		wait_pwr_up(1'b1, "the reset state");

		// power-up flag, read twice
		drive({`ZP_XT_XSTAT, `ZP_PORT_XT}, 8'h00, 1'b0, 1'b1, 1'b0);
		@(negedge clk);
		assert (dout[6] === 1'b1) else report_mismatch("first status read without pwr_up");
		drive(16'h0000, 8'h00, 1'b0, 1'b0, 1'b0);
		wait_pwr_up(1'b0, "pwr_up to clear");
		drive({`ZP_XT_XSTAT, `ZP_PORT_XT}, 8'h00, 1'b0, 1'b1, 1'b0);
		@(negedge clk);
		assert (dout[6] === 1'b0) else report_mismatch("second status read with pwr_up");

		repeat (40)
			drive({CFG_IDX[$urandom % 9], `ZP_PORT_XT}, $urandom, 1'b1, 1'b0, 1'b0);
		drive({`ZP_XT_RAMPAGE + 8'd2, `ZP_PORT_XT}, 8'h00, 1'b0, 1'b1, 1'b0);
		drive({`ZP_XT_RAMPAGE + 8'd3, `ZP_PORT_XT}, 8'h00, 1'b0, 1'b1, 1'b0);

		// every index up to the tile offsets gets one write
		for (int i = 0; i < 8'h48; i++)
			drive({i[7:0], `ZP_PORT_XT}, $urandom, 1'b1, 1'b0, 1'b0);

		// strobes, iowr_s random
		repeat (80)
		begin
			idx = $urandom;
			drive({idx, `ZP_PORT_XT}, $urandom, $urandom, 1'b0, 1'b0);
		end
		repeat (10)
		begin
			idx = $urandom;
			drive({idx, `ZP_PORT_FE}, $urandom, $urandom, 1'b0, 1'b0);
			drive({idx, `ZP_PORT_COVOX}, $urandom, $urandom, 1'b0, 1'b0);
		end

		// 7FFD paging under each lock source
		drive({`ZP_XT_MEMCONF, `ZP_PORT_XT}, 8'h00, 1'b1, 1'b0, 1'b0);
		write_7ffd(8);
		drive({`ZP_XT_MEMCONF, `ZP_PORT_XT}, 8'h40, 1'b1, 1'b0, 1'b0);
		write_7ffd(8);
		drive({`ZP_XT_MEMCONF, `ZP_PORT_XT}, 8'h80, 1'b1, 1'b0, 1'b0);
		drive(16'h0000, 8'h00, 1'b0, 1'b0, 1'b1);   // opcode sets m1 lock
		write_7ffd(8);
		drive(16'h0000, 8'h40, 1'b0, 1'b0, 1'b1);
		write_7ffd(8);
		drive({8'hFF, `ZP_PORT_FD}, 8'hC7, 1'b1, 1'b0, 1'b0);   // a15 high, ignored
		drive({8'h7F, `ZP_PORT_FD}, 8'h23, 1'b1, 1'b0, 1'b0);   // 48K lock
		write_7ffd(8);

		// reads over a mix of ports
		repeat (200)
		begin
			idx = $urandom;
			case ($urandom % 8)
			0:       lo = `ZP_PORT_FE;
			1:       lo = `ZP_PORT_KJOY;
			2:       lo = `ZP_PORT_KMOUSE;
			3:       lo = `ZP_PORT_FD;
			4:       lo = `ZP_PORT_COVOX;
			5:       lo = `ZP_PORT_XT;
			6:
			begin
				lo  = `ZP_PORT_XT;
				idx = RD_IDX[$urandom % 4];
			end
			default: lo = $urandom;
			endcase
			drive({idx, lo}, $urandom, 1'b0, 1'b1, 1'b0);
		end

		drive(16'h0000, 8'h00, 1'b0, 1'b0, 1'b0);
		repeat (2) @(posedge clk);
		$display("errors %0d, timeouts %0d", errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- zports.f
+incdir+hdl
+incdir+verif
hdl/zports_pkg.sv
hdl/port_decode.sv
hdl/xt_strobes.sv
hdl/config_regs.sv
hdl/port_read_mux.sv
hdl/zports.sv
verif/zports_tb.sv
